// File: logic/relay_pkg.sv
// relay computer control package
// shared widths, opcode classes, sequencer states and control-word bit map
`default_nettype none

package relay_pkg;

  typedef logic [4:0] phase_t;   // timing phase 0..23
  typedef logic [7:0] opcode_t;  // instruction byte
  typedef logic [7:0] ctrl_t;    // control word, bits 7:6 spare

  localparam int MAX_PHASES = 24;

  localparam int CTRL_FETCH_ADDR = 0;
  localparam int CTRL_MEM_READ   = 1;
  localparam int CTRL_INST_LOAD  = 2;
  localparam int CTRL_PC_INC     = 3;
  localparam int CTRL_EXEC_SEL   = 4;
  localparam int CTRL_DEST_LOAD  = 5;

  typedef enum logic [2:0] {
    CLS_MOV8, CLS_ALU, CLS_SETAB, CLS_LDST, CLS_MOV16, CLS_INCXY, CLS_GOTO
  } instr_class_e;

  typedef enum logic {SEQ_IDLE, SEQ_RUN} seq_state_e;

  // top two bits pick the short classes, 11 falls through to bits 5:4
  function automatic instr_class_e op_class(opcode_t op);
    instr_class_e cls;
    case (op[7:6])
      2'b00:   cls = CLS_MOV8;
      2'b01:   cls = CLS_ALU;
      2'b10:   cls = CLS_SETAB;
      default: begin
        case (op[5:4])
          2'b00:   cls = CLS_LDST;
          2'b01:   cls = CLS_MOV16;
          2'b10:   cls = CLS_INCXY;
          default: cls = CLS_GOTO;
        endcase
      end
    endcase
    return cls;
  endfunction

  // abort points of the phase chain
  function automatic phase_t class_len(instr_class_e cls);
    phase_t len;
    case (cls)
      CLS_LDST:  len = phase_t'(12);
      CLS_MOV16: len = phase_t'(10);
      CLS_INCXY: len = phase_t'(14);
      CLS_GOTO:  len = phase_t'(MAX_PHASES);
      default:   len = phase_t'(8);
    endcase
    return len;
  endfunction

endpackage

`default_nettype wire

// File: logic/cycle_sequencer.sv
// instruction cycle sequencer
// steps one timing phase per clock and ends the instruction at its length
`timescale 1ns/100ps
`default_nettype none

module cycle_sequencer (
  input  logic             clock,
  input  logic             rst_n,
  input  logic             start,
  input  relay_pkg::phase_t instr_len,
  output relay_pkg::phase_t phase,
  output logic             busy,
  output logic             instr_done
);

  import relay_pkg::*;

  seq_state_e state_q;
  seq_state_e state_d;
  phase_t     phase_q;
  phase_t     phase_d;
  phase_t     last_phase;
  logic       at_last;

  assign last_phase = instr_len - phase_t'(1);

  assign at_last = (phase_q == last_phase);

  always_comb begin
    state_d = state_q;
    phase_d = phase_q;
    case (state_q)
      SEQ_IDLE: begin
        phase_d = '0;
        if (start) begin
          state_d = SEQ_RUN;  // phase 0 on the next cycle
        end
      end
      SEQ_RUN: begin
        if (at_last) begin
          phase_d = '0;
          if (!start) begin
            state_d = SEQ_IDLE;
          end
        end else begin
          phase_d = phase_q + phase_t'(1);
        end
      end
      default: begin
        state_d = SEQ_IDLE;
        phase_d = '0;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      state_q <= SEQ_IDLE;
      phase_q <= '0;
    end else begin
      state_q <= state_d;
      phase_q <= phase_d;
    end
  end

  assign phase      = phase_q;
  assign busy       = (state_q == SEQ_RUN);
  assign instr_done = busy && at_last;  // high through the last phase

endmodule

`default_nettype wire

// File: logic/instr_decoder.sv
// instruction decoder
// latches the fetched opcode, reports its length and forms the control word
`timescale 1ns/100ps
`default_nettype none

module instr_decoder (
  input  logic              clock,
  input  logic              rst_n,
  input  logic              busy,
  input  relay_pkg::phase_t  phase,
  input  relay_pkg::opcode_t next_instr,
  output relay_pkg::phase_t  instr_len,
  output relay_pkg::ctrl_t   ctrl
);

  import relay_pkg::*;

  localparam phase_t PH_READ_FIRST = phase_t'(1);
  localparam phase_t PH_INST_LOAD  = phase_t'(4);
  localparam phase_t PH_FETCH_LAST = phase_t'(5);
  localparam phase_t PH_PC_INC     = phase_t'(6);
  localparam phase_t PH_EXEC_FIRST = phase_t'(7);

  opcode_t      cur_op;
  instr_class_e cur_cls;
  phase_t       cur_len;
  logic         inst_load;
  logic         op_known;
  phase_t       exec_last;
  phase_t       dest_phase;

  assign inst_load = busy && (phase == PH_INST_LOAD);

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      cur_op <= '0;
    end else if (inst_load) begin
      cur_op <= next_instr;  // instruction register load
    end
  end

  assign cur_cls = op_class(cur_op);
  assign cur_len = class_len(cur_cls);

  // until the opcode is in, let the chain run to the end
  assign op_known  = busy && (phase > PH_INST_LOAD);
  assign instr_len = op_known ? cur_len : phase_t'(MAX_PHASES);

  assign exec_last  = instr_len - phase_t'(2);
  assign dest_phase = instr_len - phase_t'(1);

  always_comb begin
    ctrl = '0;
    if (busy) begin
      ctrl[CTRL_FETCH_ADDR] = (phase <= PH_FETCH_LAST);
      ctrl[CTRL_MEM_READ]   = (phase >= PH_READ_FIRST) && (phase <= PH_INST_LOAD);
      ctrl[CTRL_INST_LOAD]  = inst_load;
      ctrl[CTRL_PC_INC]     = (phase == PH_PC_INC);
      ctrl[CTRL_EXEC_SEL]   = (phase >= PH_EXEC_FIRST) && (phase <= exec_last);  // empty for 8
      ctrl[CTRL_DEST_LOAD]  = (phase == dest_phase);
    end
  end

endmodule

`default_nettype wire

// File: logic/seq_regs.sv
// sequencer register block
// APB slave holding run/step control, the next opcode, status and a
// count of completed instructions
`timescale 1ns/100ps
`default_nettype none

module seq_regs #(
  parameter int APB_AW = 4,
  parameter int CNT_W  = 16
) (
  input  logic              clock,
  input  logic              rst_n,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [APB_AW-1:0] paddr,
  input  logic [31:0]       pwdata,
  output logic [31:0]       prdata,
  input  relay_pkg::phase_t  phase,
  input  logic              busy,
  input  logic              instr_done,
  output logic              start,
  output relay_pkg::opcode_t next_instr
);

  localparam logic [APB_AW-1:0] ADDR_CTRL   = APB_AW'(4'h0);
  localparam logic [APB_AW-1:0] ADDR_NEXT   = APB_AW'(4'h4);
  localparam logic [APB_AW-1:0] ADDR_STATUS = APB_AW'(4'h8);
  localparam logic [APB_AW-1:0] ADDR_COUNT  = APB_AW'(4'hc);

  logic             wr_en;
  logic             wr_ctrl;
  logic             wr_next;
  logic             wr_count;
  logic             run_q;
  logic             step_q;
  logic [CNT_W-1:0] count_q;

  assign wr_en    = psel && penable && pwrite;
  assign wr_ctrl  = wr_en && (paddr == ADDR_CTRL);
  assign wr_next  = wr_en && (paddr == ADDR_NEXT);
  assign wr_count = wr_en && (paddr == ADDR_COUNT);

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      run_q  <= 1'b0;
      step_q <= 1'b0;
    end else begin
      if (wr_ctrl) begin
        run_q <= pwdata[0];
      end
      if (wr_ctrl && pwdata[1]) begin
        step_q <= 1'b1;  // one instruction requested
      end else if (instr_done) begin
        step_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      next_instr <= '0;
    end else if (wr_next) begin
      next_instr <= pwdata[7:0];
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      count_q <= '0;
    end else if (wr_count) begin
      count_q <= '0;  // any write clears
    end else if (instr_done) begin
      count_q <= count_q + CNT_W'(1);
    end
  end

  // a step is used up in its last phase, so it must not restart the chain
  assign start = run_q || (step_q && !instr_done);

  always_comb begin
    case (paddr)
      ADDR_CTRL:   prdata = {31'd0, run_q};  // step reads back 0
      ADDR_NEXT:   prdata = {24'd0, next_instr};
      ADDR_STATUS: prdata = {19'd0, phase, 7'd0, busy};
      ADDR_COUNT:  prdata = 32'(count_q);
      default:     prdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: logic/relay_control_top.sv
// relay computer instruction-cycle controller
// APB registers drive the phase sequencer, the decoder turns phase and
// opcode into the control word
`timescale 1ns/100ps
`default_nettype none

module relay_control_top #(
  parameter int APB_AW = 4,
  parameter int CNT_W  = 16
) (
  input  logic              clock,
  input  logic              rst_n,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [APB_AW-1:0] paddr,
  input  logic [31:0]       pwdata,
  output logic [31:0]       prdata,
  output relay_pkg::phase_t  phase,
  output relay_pkg::ctrl_t   ctrl,
  output logic              instr_done
);

  import relay_pkg::*;

  logic    start;
  logic    busy;
  opcode_t next_instr;
  phase_t  instr_len;

  seq_regs #(
    .APB_AW (APB_AW),
    .CNT_W  (CNT_W)
  ) u_seq_regs (
    .clock      (clock),
    .rst_n      (rst_n),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .phase      (phase),
    .busy       (busy),
    .instr_done (instr_done),
    .start      (start),
    .next_instr (next_instr)
  );

  cycle_sequencer u_cycle_sequencer (
    .clock      (clock),
    .rst_n      (rst_n),
    .start      (start),
    .instr_len  (instr_len),
    .phase      (phase),
    .busy       (busy),
    .instr_done (instr_done)
  );

  instr_decoder u_instr_decoder (
    .clock      (clock),
    .rst_n      (rst_n),
    .busy       (busy),
    .phase      (phase),
    .next_instr (next_instr),
    .instr_len  (instr_len),
    .ctrl       (ctrl)
  );

endmodule

`default_nettype wire

// File: tests/control_checker.sv
// control-word checker for the relay controller
// follows each instruction phase by phase and compares phase, ctrl and
// instr_done with the class and control rules
`timescale 1ns/100ps
`default_nettype none

module control_checker (
  input  logic               clock,
  input  logic               rst_n,
  input  relay_pkg::phase_t  phase,
  input  relay_pkg::ctrl_t   ctrl,
  input  logic               instr_done,
  input  relay_pkg::opcode_t next_op,
  input  logic               expect_b2b,
  output int                 err_count,
  output int                 done_count
);

  import relay_pkg::*;

  logic active;
  logic prev_done;
  int   exp_phase;
  int   cur_len;

  function automatic int length_of(opcode_t op);
    int len;
    case (op[5:4])
      2'b00:   len = 12;  // LDST
      2'b01:   len = 10;  // MOV16
      2'b10:   len = 14;  // INCXY
      default: len = 24;  // GOTO
    endcase
    if (op[7:6] != 2'b11) begin
      len = 8;  // MOV8, ALU, SETAB
    end
    return len;
  endfunction

  function automatic ctrl_t expected_ctrl(int p, int len);
    ctrl_t c;
    c = '0;
    c[CTRL_FETCH_ADDR] = (p <= 5);
    c[CTRL_MEM_READ]   = (p >= 1) && (p <= 4);
    c[CTRL_INST_LOAD]  = (p == 4);
    c[CTRL_PC_INC]     = (p == 6);
    c[CTRL_EXEC_SEL]   = (p >= 7) && (p <= len - 2);  // empty span for 8
    c[CTRL_DEST_LOAD]  = (p == len - 1);
    return c;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch: %s got %h expected %h at phase %0d", name, got, exp, exp_phase);
      err_count++;
    end
  endtask

  // sampled mid-cycle, away from the edges
  always @(negedge clock) begin
    if (!rst_n) begin
      active     = 1'b0;
      prev_done  = 1'b0;
      exp_phase  = 0;
      cur_len    = MAX_PHASES;
      err_count  = 0;
      done_count = 0;
    end else begin
      if (!active) begin
        if (ctrl[CTRL_FETCH_ADDR]) begin
          active    = 1'b1;  // phase 0 of a new instruction
          exp_phase = 0;
          cur_len   = MAX_PHASES;
        end else begin
          if (expect_b2b && prev_done) begin
            $display("idle cycle between back-to-back instructions at %0t", $time);
            err_count++;
          end
          check_value("phase", 32'(phase), 32'h0);
          check_value("ctrl", 32'(ctrl), 32'h0);
          check_value("instr_done", 32'(instr_done), 32'h0);
        end
        prev_done = 1'b0;
      end
      if (active) begin
        check_value("phase", 32'(phase), 32'(exp_phase));
        check_value("ctrl", 32'(ctrl), 32'(expected_ctrl(exp_phase, cur_len)));
        check_value("instr_done", 32'(instr_done), 32'(exp_phase == cur_len - 1));
        if (exp_phase == 4) begin
          cur_len = length_of(next_op);  // opcode taken at the end of phase 4
        end
        if (exp_phase == cur_len - 1) begin
          active    = 1'b0;
          prev_done = 1'b1;
          done_count++;
        end else begin
          exp_phase++;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: tests/tb_relay_control.sv
// testbench for the relay instruction-cycle controller
// steps every opcode class, runs random bursts over APB and checks COUNT
`timescale 1ns/100ps
`default_nettype none

module tb_relay_control;

  import relay_pkg::*;

  localparam logic [3:0] ADDR_CTRL   = 4'h0;
  localparam logic [3:0] ADDR_NEXT   = 4'h4;
  localparam logic [3:0] ADDR_STATUS = 4'h8;
  localparam logic [3:0] ADDR_COUNT  = 4'hc;

  typedef struct packed {
    logic [7:0] op;
    logic       run;   // 0 step, 1 run burst
    logic [7:0] reps;  // steps, or instructions in the burst
    logic [7:0] len;   // cycles per instruction of op
  } stim_t;

  localparam int N_ROWS = 10;

  stim_t stim [N_ROWS] = '{
    '{8'h12, 1'b0, 8'd1,  8'd8},   // MOV8
    '{8'h5a, 1'b0, 8'd1,  8'd8},   // ALU
    '{8'h8f, 1'b0, 8'd1,  8'd8},   // SETAB
    '{8'hc3, 1'b0, 8'd1,  8'd12},  // LDST
    '{8'hd0, 1'b0, 8'd1,  8'd10},  // MOV16
    '{8'he7, 1'b0, 8'd1,  8'd14},  // INCXY
    '{8'hf1, 1'b0, 8'd2,  8'd24},  // GOTO
    '{8'hc9, 1'b1, 8'd12, 8'd12},
    '{8'h40, 1'b1, 8'd20, 8'd8},
    '{8'hfe, 1'b1, 8'd3,  8'd24}
  };

  logic        clock;
  logic        rst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [3:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  phase_t      phase;
  ctrl_t       ctrl;
  logic        instr_done;
  opcode_t     next_op_model;  // mirror of NEXT_INSTR
  logic        expect_b2b;
  int          chk_errors;
  int          chk_done;
  int          tb_errors;
  int          errs_seen;
  int          count_base;
  int          total;
  logic [31:0] rng;
  logic [31:0] rd;

  always #4 clock = ~clock;

  relay_control_top #(
    .APB_AW (4),
    .CNT_W  (16)
  ) u_relay_control_top (
    .clock      (clock),
    .rst_n      (rst_n),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .phase      (phase),
    .ctrl       (ctrl),
    .instr_done (instr_done)
  );

  control_checker u_checker (
    .clock      (clock),
    .rst_n      (rst_n),
    .phase      (phase),
    .ctrl       (ctrl),
    .instr_done (instr_done),
    .next_op    (next_op_model),
    .expect_b2b (expect_b2b),
    .err_count  (chk_errors),
    .done_count (chk_done)
  );

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic timeout_abort(input string what);
    $display("timeout while waiting for %s", what);
    $display("*** TEST FAILED ***");
    $finish;
  endtask

  task automatic expect_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch: %s got %h expected %h", name, got, exp);
      tb_errors++;
    end
  endtask

  // called 1 ns after a rising edge, returns at the same point
  task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
    psel    = 1'b1;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    penable = 1'b0;
    @(posedge clock);
    #1;
    penable = 1'b1;
    @(posedge clock);  // write taken here
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    if (addr == ADDR_NEXT) begin
      next_op_model = data[7:0];
    end
  endtask

  task automatic apb_read(input logic [3:0] addr, output logic [31:0] data);
    psel    = 1'b1;
    pwrite  = 1'b0;
    paddr   = addr;
    penable = 1'b0;
    @(posedge clock);
    #1;
    penable = 1'b1;
    #3;
    data = prdata;  // mid access cycle
    @(posedge clock);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic wait_phase(input phase_t target);
    logic found;
    found = 1'b0;
    for (int i = 0; i < 64 && !found; i++) begin
      @(posedge clock);
      #1;
      found = (phase == target);
    end
    if (!found) timeout_abort("a phase");
  endtask

  task automatic wait_done(output int cycles);
    logic seen;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < 64) begin
      @(posedge clock);
      #1;
      cycles++;
      seen = instr_done;
    end
    if (!seen) timeout_abort("instr_done");
  endtask

  task automatic wait_idle();
    logic [31:0] status;
    int          tries;
    status = 32'h1;
    tries  = 0;
    while (status[0] && tries < 40) begin
      apb_read(ADDR_STATUS, status);
      tries++;
    end
    if (status[0]) timeout_abort("the sequencer to go idle");
  endtask

  task automatic report_test(input string name);
    int errs;
    errs = tb_errors + chk_errors - errs_seen;
    if (errs == 0) begin
      $display("%-8s ok", name);
    end else begin
      $display("%-8s failed, %0d errors", name, errs);
    end
    errs_seen = tb_errors + chk_errors;
  endtask

  task automatic step_row(input stim_t row);
    int cycles;
    for (int r = 0; r < int'(row.reps); r++) begin
      apb_write(ADDR_NEXT, 32'(row.op));
      apb_write(ADDR_CTRL, 32'h2);
      wait_done(cycles);  // counted from phase 0
      expect_value("step cycles", 32'(cycles), 32'(row.len));
      wait_idle();
    end
  endtask

  task automatic burst_row(input stim_t row);
    logic [31:0] count;
    int          done_before;
    done_before = chk_done;
    apb_write(ADDR_NEXT, 32'(row.op));
    expect_b2b = 1'b1;
    apb_write(ADDR_CTRL, 32'h1);
    for (int k = 1; k < int'(row.reps); k++) begin
      wait_phase(phase_t'(5));
      rng = xorshift32(rng);
      apb_write(ADDR_NEXT, {24'd0, rng[7:0]});  // after the current opcode is in
    end
    wait_phase(phase_t'(5));
    expect_b2b = 1'b0;
    apb_write(ADDR_CTRL, 32'h0);  // last instruction runs to its end
    wait_idle();
    expect_value("instr_done pulses", 32'(chk_done - done_before), 32'(row.reps));
    apb_read(ADDR_COUNT, count);
    expect_value("COUNT", count, 32'(chk_done - count_base));
    apb_write(ADDR_COUNT, 32'h0000_00a5);  // any value clears
    count_base = chk_done;
    apb_read(ADDR_COUNT, count);
    expect_value("COUNT", count, 32'h0);
  endtask

  initial begin
    clock         = 1'b0;
    rst_n         = 1'b0;
    psel          = 1'b0;
    penable       = 1'b0;
    pwrite        = 1'b0;
    paddr         = '0;
    pwdata        = '0;
    next_op_model = '0;
    expect_b2b    = 1'b0;
    tb_errors     = 0;
    errs_seen     = 0;
    count_base    = 0;
    rng           = 32'hc05b;
    repeat (3) @(posedge clock);
    #1;
    rst_n = 1'b1;
    repeat (4) @(posedge clock);
    #1;
    expect_value("phase", 32'(phase), 32'h0);
    expect_value("ctrl", 32'(ctrl), 32'h0);
    apb_read(ADDR_STATUS, rd);
    expect_value("STATUS", rd, 32'h0);
    expect_value("instr_done pulses", 32'(chk_done), 32'h0);
    report_test("reset");
    for (int i = 0; i < N_ROWS; i++) begin
      if (stim[i].run) begin
        burst_row(stim[i]);
      end else begin
        step_row(stim[i]);
      end
      report_test($sformatf("row %0d", i));
    end
    total = tb_errors + chk_errors;
    $display("tests %0d, instructions %0d, errors %0d", N_ROWS + 1, chk_done, total);
    if (total == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
logic/relay_pkg.sv
logic/cycle_sequencer.sv
logic/instr_decoder.sv
logic/seq_regs.sv
logic/relay_control_top.sv
tests/control_checker.sv
tests/tb_relay_control.sv

// File: Makefile
TOP := tb_relay_control

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/100ps -f tb.f --top-module $(TOP)

obj_dir/V$(TOP): tb.f logic/*.sv tests/*.sv
	verilator --binary --timing --timescale 1ns/100ps -f tb.f --top-module $(TOP) -Mdir obj_dir

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -qF "*** TEST PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log
